// File: qerv_pkg.sv
`default_nettype none

package qerv_pkg;

   // Only a 4-bit serial slice is supported in this core
   localparam int W      = 4;
   localparam int NSTEPS = 32 / W;

   typedef logic [31:0]                word_t;
   typedef logic [W-1:0]               nibble_t;
   typedef logic [4:0]                 reg_addr_t;
   typedef logic [$clog2(NSTEPS)-1:0]  step_t;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_DECODE,
      ST_RF_WAIT,
      ST_EXEC
   } core_state_t;

   typedef enum logic [1:0] {
      RD_NONE,
      RD_ALU,
      RD_IMM,
      RD_LINK
   } rd_src_t;

   typedef enum logic [1:0] {
      BOOL_NONE,
      BOOL_XOR,
      BOOL_OR,
      BOOL_AND
   } bool_op_t;

   typedef enum logic [1:0] {
      IMM_I,
      IMM_U,
      IMM_J
   } imm_type_t;

   typedef struct packed {
      logic      alu_sub;
      bool_op_t  bool_op;
      logic      op_b_imm;
      rd_src_t   rd_src;
      logic      jump;
      imm_type_t imm_type;
   } dec_ctrl_t;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      rreq;
   } rf_read_t;

   typedef struct packed {
      logic      wen;
      reg_addr_t waddr;
      nibble_t   wdata;
   } rf_write_t;

   typedef struct packed {
      nibble_t rs1;
      nibble_t rs2;
   } rf_rdata_t;

endpackage

`default_nettype wire

// File: qerv_state.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_state (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_ibus_ack,
   input  logic            i_rf_ready,
   output logic            o_ibus_cyc,
   output logic            o_rf_rreq,
   output logic            o_cnt_en,
   output qerv_pkg::step_t o_step,
   output logic            o_cnt_done,
   output logic            o_pc_en
);

   qerv_pkg::core_state_t state;
   qerv_pkg::core_state_t state_nxt;
   qerv_pkg::step_t       step;

   always_comb begin
      state_nxt = state;
      case (state)
         qerv_pkg::ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = qerv_pkg::ST_DECODE;
            end
         end
         qerv_pkg::ST_DECODE: begin
            // Ready may already come back in the request cycle
            state_nxt = i_rf_ready ? qerv_pkg::ST_EXEC : qerv_pkg::ST_RF_WAIT;
         end
         qerv_pkg::ST_RF_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = qerv_pkg::ST_EXEC;
            end
         end
         qerv_pkg::ST_EXEC: begin
            if (o_cnt_done) begin
               state_nxt = qerv_pkg::ST_FETCH;
            end
         end
         default: begin
            state_nxt = qerv_pkg::ST_FETCH;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= qerv_pkg::ST_FETCH;
         step  <= '0;
      end else begin
         state <= state_nxt;
         // Wraps back to zero after the last nibble
         if (o_cnt_en) begin
            step <= step + qerv_pkg::step_t'(1);
         end
      end
   end

   assign o_ibus_cyc = (state == qerv_pkg::ST_FETCH);
   assign o_rf_rreq  = (state == qerv_pkg::ST_DECODE);
   assign o_cnt_en   = (state == qerv_pkg::ST_EXEC);
   assign o_pc_en    = (state == qerv_pkg::ST_EXEC);
   assign o_step     = step;
   assign o_cnt_done = o_cnt_en && (step == qerv_pkg::step_t'(qerv_pkg::NSTEPS - 1));

   // A fetch holds until the bus acknowledges
   assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc);

   assert property (@(posedge clk) disable iff (!i_rst_n) o_rf_rreq |=> !o_rf_rreq);

   // Every execute phase starts on the lowest nibble
   assert property (@(posedge clk) disable iff (!i_rst_n) $rose(o_cnt_en) |-> o_step == '0);

endmodule

`default_nettype wire

// File: qerv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_decode (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_ibus_ack,
   input  qerv_pkg::word_t     i_instr,
   output qerv_pkg::dec_ctrl_t o_ctrl
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   logic [6:0]         opcode;
   logic [2:0]         funct3;
   logic               funct7_b5;
   qerv_pkg::bool_op_t bool_op;

   function automatic qerv_pkg::bool_op_t bool_of(input logic [2:0] f3);
      case (f3)
         3'b100:  return qerv_pkg::BOOL_XOR;
         3'b110:  return qerv_pkg::BOOL_OR;
         3'b111:  return qerv_pkg::BOOL_AND;
         default: return qerv_pkg::BOOL_NONE;
      endcase
   endfunction

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode    <= '0;
         funct3    <= '0;
         funct7_b5 <= 1'b0;
      end else if (i_ibus_ack) begin
         opcode    <= i_instr[6:0];
         funct3    <= i_instr[14:12];
         funct7_b5 <= i_instr[30];
      end
   end

   assign bool_op = bool_of(funct3);

   // Anything not matched below stays a no-op
   always_comb begin
      o_ctrl = '0;
      case (opcode)
         OPC_OP: begin
            if (funct3 == 3'b000) begin
               o_ctrl.rd_src  = qerv_pkg::RD_ALU;
               o_ctrl.alu_sub = funct7_b5;
            end else if (bool_op != qerv_pkg::BOOL_NONE && !funct7_b5) begin
               o_ctrl.rd_src  = qerv_pkg::RD_ALU;
               o_ctrl.bool_op = bool_op;
            end
         end
         OPC_OP_IMM: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.imm_type = qerv_pkg::IMM_I;
            if (funct3 == 3'b000 || bool_op != qerv_pkg::BOOL_NONE) begin
               o_ctrl.rd_src  = qerv_pkg::RD_ALU;
               o_ctrl.bool_op = bool_op;
            end
         end
         OPC_LUI: begin
            o_ctrl.rd_src   = qerv_pkg::RD_IMM;
            o_ctrl.imm_type = qerv_pkg::IMM_U;
         end
         OPC_JAL: begin
            o_ctrl.rd_src   = qerv_pkg::RD_LINK;
            o_ctrl.jump     = 1'b1;
            o_ctrl.imm_type = qerv_pkg::IMM_J;
         end
         default: begin
            o_ctrl.rd_src = qerv_pkg::RD_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: qerv_immdec.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_immdec (
   input  logic                clk,
   input  logic                i_ibus_ack,
   input  qerv_pkg::word_t     i_instr,
   input  logic                i_cnt_en,
   input  qerv_pkg::imm_type_t i_imm_type,
   output qerv_pkg::reg_addr_t o_rs1_addr,
   output qerv_pkg::reg_addr_t o_rs2_addr,
   output qerv_pkg::reg_addr_t o_rd_addr,
   output qerv_pkg::nibble_t   o_imm
);

   localparam int W = qerv_pkg::W;

   logic [31:12]    imm_raw;
   logic            load;
   qerv_pkg::word_t imm_full;
   qerv_pkg::word_t imm_sr;

   always_comb begin
      case (i_imm_type)
         qerv_pkg::IMM_U: imm_full = {imm_raw[31:12], 12'd0};
         qerv_pkg::IMM_J: imm_full = {{12{imm_raw[31]}}, imm_raw[19:12], imm_raw[20],
                                      imm_raw[30:21], 1'b0};
         default:         imm_full = {{20{imm_raw[31]}}, imm_raw[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      load <= i_ibus_ack;
      if (i_ibus_ack) begin
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
         o_rd_addr  <= i_instr[11:7];
         imm_raw    <= i_instr[31:12];
      end
      // Immediate type comes from the decoder one cycle after the ack
      if (load) begin
         imm_sr <= imm_full;
      end else if (i_cnt_en) begin
         imm_sr <= {{W{imm_sr[31]}}, imm_sr[31:W]};
      end
   end

   assign o_imm = imm_sr[W-1:0];

endmodule

`default_nettype wire

// File: qerv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_alu (
   input  logic                clk,
   input  logic                i_cnt_en,
   input  qerv_pkg::step_t     i_step,
   input  qerv_pkg::dec_ctrl_t i_ctrl,
   input  qerv_pkg::nibble_t   i_rs1,
   input  qerv_pkg::nibble_t   i_rs2,
   input  qerv_pkg::nibble_t   i_imm,
   output qerv_pkg::nibble_t   o_rd
);

   localparam int W = qerv_pkg::W;

   qerv_pkg::nibble_t op_b;
   qerv_pkg::nibble_t b_add;
   qerv_pkg::nibble_t bool_rd;
   logic              carry_in;
   logic              carry_q;
   logic [W:0]        sum;

   assign op_b = i_ctrl.op_b_imm ? i_imm : i_rs2;

   // Subtract is rs1 + ~b with the extra one entering at step 0
   assign b_add    = i_ctrl.alu_sub ? ~op_b : op_b;
   assign carry_in = (i_step == '0) ? i_ctrl.alu_sub : carry_q;
   assign sum      = {1'b0, i_rs1} + {1'b0, b_add} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= sum[W];
      end
   end

   always_comb begin
      case (i_ctrl.bool_op)
         qerv_pkg::BOOL_XOR: bool_rd = i_rs1 ^ op_b;
         qerv_pkg::BOOL_OR:  bool_rd = i_rs1 | op_b;
         qerv_pkg::BOOL_AND: bool_rd = i_rs1 & op_b;
         default:            bool_rd = '0;
      endcase
   end

   assign o_rd = (i_ctrl.bool_op == qerv_pkg::BOOL_NONE) ? sum[W-1:0] : bool_rd;

endmodule

`default_nettype wire

// File: qerv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_ctrl #(
   parameter qerv_pkg::word_t RESET_PC = '0
) (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_pc_en,
   input  qerv_pkg::step_t   i_step,
   input  logic              i_jump,
   input  qerv_pkg::nibble_t i_imm,
   output qerv_pkg::word_t   o_ibus_adr,
   output qerv_pkg::nibble_t o_link
);

   localparam int W = qerv_pkg::W;

   qerv_pkg::word_t   pc;
   qerv_pkg::nibble_t inc;
   qerv_pkg::nibble_t offset;
   logic              first;
   logic              pc_carry;
   logic              link_carry;
   logic              pc_cin;
   logic              link_cin;
   logic [W:0]        pc_sum;
   logic [W:0]        link_sum;

   assign first = (i_step == '0);

   // The constant 4 only lands in the lowest nibble
   assign inc    = first ? qerv_pkg::nibble_t'(4) : '0;
   assign offset = i_jump ? i_imm : inc;

   assign pc_cin   = first ? 1'b0 : pc_carry;
   assign link_cin = first ? 1'b0 : link_carry;
   assign pc_sum   = {1'b0, pc[W-1:0]} + {1'b0, offset} + {{W{1'b0}}, pc_cin};
   assign link_sum = {1'b0, pc[W-1:0]} + {1'b0, inc} + {{W{1'b0}}, link_cin};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= RESET_PC;
      end else if (i_pc_en) begin
         pc <= {pc_sum[W-1:0], pc[31:W]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         pc_carry   <= pc_sum[W];
         link_carry <= link_sum[W];
      end
   end

   assign o_ibus_adr = pc;
   assign o_link     = link_sum[W-1:0];

   // Outside the rotation the PC is word aligned
   assert property (@(posedge clk) disable iff (!i_rst_n) !i_pc_en |-> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: qerv_rf_if.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_rf_if (
   input  logic                i_cnt_en,
   input  qerv_pkg::dec_ctrl_t i_ctrl,
   input  qerv_pkg::reg_addr_t i_rs1_addr,
   input  qerv_pkg::reg_addr_t i_rs2_addr,
   input  qerv_pkg::reg_addr_t i_rd_addr,
   input  logic                i_rf_rreq,
   input  qerv_pkg::nibble_t   i_alu_rd,
   input  qerv_pkg::nibble_t   i_imm,
   input  qerv_pkg::nibble_t   i_link,
   output qerv_pkg::rf_read_t  o_rf_read,
   output qerv_pkg::rf_write_t o_rf_write
);

   qerv_pkg::nibble_t rd_nib;

   always_comb begin
      case (i_ctrl.rd_src)
         qerv_pkg::RD_ALU:  rd_nib = i_alu_rd;
         qerv_pkg::RD_IMM:  rd_nib = i_imm;
         qerv_pkg::RD_LINK: rd_nib = i_link;
         default:           rd_nib = '0;
      endcase
   end

   assign o_rf_read.rs1  = i_rs1_addr;
   assign o_rf_read.rs2  = i_rs2_addr;
   assign o_rf_read.rreq = i_rf_rreq;

   // x0 and no-ops never reach the register file
   assign o_rf_write.wen   = i_cnt_en && (i_ctrl.rd_src != qerv_pkg::RD_NONE) &&
                             (i_rd_addr != '0);
   assign o_rf_write.waddr = i_rd_addr;
   assign o_rf_write.wdata = rd_nib;

endmodule

`default_nettype wire

// File: qerv_top.sv
`timescale 1ns/1ps
`default_nettype none

module qerv_top #(
   parameter qerv_pkg::word_t RESET_PC = '0
) (
   input  logic                clk,
   input  logic                i_rst_n,
   output qerv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  qerv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   output qerv_pkg::rf_read_t  o_rf_read,
   input  logic                i_rf_ready,
   input  qerv_pkg::rf_rdata_t i_rf_rdata,
   output qerv_pkg::rf_write_t o_rf_write
);

   logic                rf_rreq;
   logic                cnt_en;
   logic                pc_en;
   qerv_pkg::step_t     step;
   qerv_pkg::dec_ctrl_t ctrl;
   qerv_pkg::reg_addr_t rs1_addr;
   qerv_pkg::reg_addr_t rs2_addr;
   qerv_pkg::reg_addr_t rd_addr;
   qerv_pkg::nibble_t   imm;
   qerv_pkg::nibble_t   alu_rd;
   qerv_pkg::nibble_t   link;

   qerv_state u_state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_step     (step),
      .o_cnt_done (),
      .o_pc_en    (pc_en)
   );

   qerv_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .o_ctrl     (ctrl)
   );

   qerv_immdec u_immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .i_imm_type (ctrl.imm_type),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_imm      (imm)
   );

   qerv_alu u_alu (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_step   (step),
      .i_ctrl   (ctrl),
      .i_rs1    (i_rf_rdata.rs1),
      .i_rs2    (i_rf_rdata.rs2),
      .i_imm    (imm),
      .o_rd     (alu_rd)
   );

   qerv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_pc_en    (pc_en),
      .i_step     (step),
      .i_jump     (ctrl.jump),
      .i_imm      (imm),
      .o_ibus_adr (o_ibus_adr),
      .o_link     (link)
   );

   qerv_rf_if u_rf_if (
      .i_cnt_en   (cnt_en),
      .i_ctrl     (ctrl),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rf_rreq  (rf_rreq),
      .i_alu_rd   (alu_rd),
      .i_imm      (imm),
      .i_link     (link),
      .o_rf_read  (o_rf_read),
      .o_rf_write (o_rf_write)
   );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic o_clk
);

   logic clk_q = 1'b0;

   always #(PERIOD_NS / 2) clk_q = ~clk_q;

   assign o_clk = clk_q;

endmodule

`default_nettype wire

// File: tb_qerv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qerv;

   localparam qerv_pkg::word_t RESET_PC = 32'h0000_0100;
   localparam int NUM_INSTR      = 200;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
   localparam int NSTEPS         = qerv_pkg::NSTEPS;

   logic                clk;
   logic                rst_n = 1'b0;
   qerv_pkg::word_t     ibus_adr;
   logic                ibus_cyc;
   qerv_pkg::word_t     ibus_rdt = '0;
   logic                ibus_ack = 1'b0;
   qerv_pkg::rf_read_t  rf_read;
   logic                rf_ready = 1'b0;
   qerv_pkg::rf_rdata_t rf_rdata = '0;
   qerv_pkg::rf_write_t rf_write;

   // Memories and architectural state
   qerv_pkg::word_t imem [0:255];
   qerv_pkg::word_t rf_mem [0:31];
   qerv_pkg::word_t arch_x [0:31];
   qerv_pkg::word_t model_pc;

   // Expected outcome of the instruction in flight
   qerv_pkg::word_t     exp_result;
   qerv_pkg::word_t     exp_next_pc;
   logic                exp_wen;
   qerv_pkg::reg_addr_t exp_rd;
   qerv_pkg::reg_addr_t exp_rs1;
   qerv_pkg::reg_addr_t exp_rs2;

   int                  ack_wait  = -1;
   int                  rf_wait   = 0;
   logic                exec_next = 1'b0;
   int                  drv_step  = -1;
   qerv_pkg::reg_addr_t rs1_lat;
   qerv_pkg::reg_addr_t rs2_lat;
   qerv_pkg::word_t     collected;
   int                  retired = 0;
   int                  cycles  = 0;

   tb_clk_gen #(.PERIOD_NS (4)) u_clk_gen (.o_clk (clk));

   qerv_top #(
      .RESET_PC (RESET_PC)
   ) uut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_read  (rf_read),
      .i_rf_ready (rf_ready),
      .i_rf_rdata (rf_rdata),
      .o_rf_write (rf_write)
   );

   task automatic flag_mismatch(input string what, input qerv_pkg::word_t got,
                                input qerv_pkg::word_t expected);
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("TEST FAIL");
      $fatal(1, "wrong value");
   endtask

   task automatic abort_on_timeout();
      $display("Timeout: the core retired only %0d of %0d instructions in %0d cycles",
               retired, NUM_INSTR, cycles);
      $display("TEST FAIL");
      $fatal(1, "timeout");
   endtask

   function automatic qerv_pkg::word_t reg_init(input int idx);
      return (idx == 0) ? '0 : (qerv_pkg::word_t'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
   endfunction

   function automatic qerv_pkg::nibble_t nibble_of(input qerv_pkg::word_t w, input int k);
      return qerv_pkg::nibble_t'(w >> (4 * k));
   endfunction

   function automatic logic [2:0] alu_funct3();
      case (int'($urandom % 4))
         0:       return 3'b000;
         1:       return 3'b100;
         2:       return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   // Mostly supported instructions with about one in sixteen unsupported
   function automatic qerv_pkg::word_t gen_instr();
      int                  sel;
      logic [4:0]          rd;
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [2:0]          f3;
      logic [6:0]          f7;
      logic [20:0]         joff;
      qerv_pkg::word_t     instr;
      sel  = int'($urandom % 16);
      rd   = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom);
      rs1  = 5'($urandom);
      rs2  = 5'($urandom);
      f3   = alu_funct3();
      f7   = (f3 == 3'b000 && $urandom % 2 == 1) ? 7'b0100000 : 7'b0000000;
      joff = {19'($urandom), 2'b00};
      if (sel < 5) begin
         instr = {f7, rs2, rs1, f3, rd, 7'b0110011};
      end else if (sel < 10) begin
         instr = {12'($urandom), rs1, f3, rd, 7'b0010011};
      end else if (sel < 12 || sel == 15) begin
         instr = {20'($urandom), rd, 7'b0110111};
      end else if (sel < 14) begin
         instr = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      end else begin
         case (int'($urandom % 4))
            0:       instr = {7'($urandom), rs2, rs1, 3'b000, 5'($urandom), 7'b1100011};
            1:       instr = {12'($urandom), rs1, 3'b010, rd, 7'b0000011};
            2:       instr = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0010011};
            default: instr = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
         endcase
      end
      return instr;
   endfunction

   // RV32I reference for the kept subset
   task automatic execute_model(input qerv_pkg::word_t instr, input qerv_pkg::word_t pc);
      logic [6:0]      opcode;
      logic [2:0]      f3;
      logic [6:0]      f7;
      logic            valid;
      qerv_pkg::word_t a;
      qerv_pkg::word_t b;
      qerv_pkg::word_t imm_i;
      qerv_pkg::word_t imm_u;
      qerv_pkg::word_t imm_j;
      opcode = instr[6:0];
      f3     = instr[14:12];
      f7     = instr[31:25];
      a      = arch_x[instr[19:15]];
      b      = arch_x[instr[24:20]];
      imm_i  = {{20{instr[31]}}, instr[31:20]};
      imm_u  = {instr[31:12], 12'h000};
      imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      valid       = 1'b1;
      exp_result  = '0;
      exp_next_pc = pc + 32'd4;
      case (opcode)
         7'b0110011: begin
            case ({f7, f3})
               10'b0000000_000: exp_result = a + b;
               10'b0100000_000: exp_result = a - b;
               10'b0000000_100: exp_result = a ^ b;
               10'b0000000_110: exp_result = a | b;
               10'b0000000_111: exp_result = a & b;
               default:         valid = 1'b0;
            endcase
         end
         7'b0010011: begin
            case (f3)
               3'b000:  exp_result = a + imm_i;
               3'b100:  exp_result = a ^ imm_i;
               3'b110:  exp_result = a | imm_i;
               3'b111:  exp_result = a & imm_i;
               default: valid = 1'b0;
            endcase
         end
         7'b0110111: exp_result = imm_u;
         7'b1101111: begin
            exp_result  = pc + 32'd4;
            exp_next_pc = pc + imm_j;
         end
         default: valid = 1'b0;
      endcase
      exp_rd  = instr[11:7];
      exp_rs1 = instr[19:15];
      exp_rs2 = instr[24:20];
      exp_wen = valid && (exp_rd != 5'd0);
   endtask

   // Bus and register file models driven on the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         ibus_ack  = 1'b0;
         rf_ready  = 1'b0;
         rf_rdata  = '0;
         ack_wait  = -1;
         rf_wait   = 0;
         exec_next = 1'b0;
         drv_step  = -1;
      end else begin
         ibus_ack = 1'b0;
         rf_ready = 1'b0;
         if (ibus_cyc) begin
            if (ack_wait < 0) begin
               ack_wait = int'($urandom % 4);
            end
            if (ack_wait == 0) begin
               ibus_ack = 1'b1;
               ibus_rdt = imem[ibus_adr[9:2]];
               execute_model(ibus_rdt, model_pc);
               ack_wait = -1;
            end else begin
               ack_wait = ack_wait - 1;
            end
         end
         // Execute steps follow the ready pulse directly
         if (exec_next) begin
            drv_step  = 0;
            exec_next = 1'b0;
         end else if (drv_step >= 0 && drv_step < NSTEPS - 1) begin
            drv_step = drv_step + 1;
         end else begin
            drv_step = -1;
         end
         if (rf_wait > 0) begin
            rf_wait = rf_wait - 1;
            if (rf_wait == 0) begin
               rf_ready  = 1'b1;
               exec_next = 1'b1;
            end
         end else if (rf_read.rreq) begin
            rs1_lat = rf_read.rs1;
            rs2_lat = rf_read.rs2;
            rf_wait = int'($urandom % 4);
            if (rf_wait == 0) begin
               rf_ready  = 1'b1;
               exec_next = 1'b1;
            end
         end
         if (drv_step >= 0) begin
            rf_rdata.rs1 = nibble_of(rf_mem[rs1_lat], drv_step);
            rf_rdata.rs2 = nibble_of(rf_mem[rs2_lat], drv_step);
         end else begin
            rf_rdata = '0;
         end
      end
   end

   // Checks on the rising edge before the core updates
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            rf_mem[5'(i)] = reg_init(i);
            arch_x[5'(i)] = reg_init(i);
         end
         model_pc = RESET_PC;
         retired  = 0;
         cycles   = 0;
      end else begin
         cycles = cycles + 1;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_on_timeout();
         end
         if (ibus_cyc) begin
            assert (ibus_adr == model_pc)
               else flag_mismatch("fetch address", ibus_adr, model_pc);
         end else begin
            assert (rf_read.rs1 == exp_rs1)
               else flag_mismatch("rs1 address", 32'(rf_read.rs1), 32'(exp_rs1));
            assert (rf_read.rs2 == exp_rs2)
               else flag_mismatch("rs2 address", 32'(rf_read.rs2), 32'(exp_rs2));
         end
         if (drv_step < 0) begin
            assert (!rf_write.wen)
               else flag_mismatch("write enable outside execute", 32'(rf_write.wen), '0);
         end else begin
            assert (rf_write.wen == exp_wen)
               else flag_mismatch("write enable", 32'(rf_write.wen), 32'(exp_wen));
            if (drv_step == 0) begin
               collected = '0;
            end
            if (rf_write.wen) begin
               assert (rf_write.waddr == exp_rd)
                  else flag_mismatch("write address", 32'(rf_write.waddr), 32'(exp_rd));
               collected = collected | (qerv_pkg::word_t'(rf_write.wdata) << (4 * drv_step));
            end
            if (drv_step == NSTEPS - 1) begin
               if (exp_wen) begin
                  assert (collected == exp_result)
                     else flag_mismatch("rd result", collected, exp_result);
                  rf_mem[exp_rd] = collected;
                  arch_x[exp_rd] = exp_result;
               end
               model_pc = exp_next_pc;
               retired  = retired + 1;
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h4faf));
      for (int i = 0; i < 256; i++) begin
         imem[8'(i)] = gen_instr();
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (ibus_cyc) else flag_mismatch("ibus cyc in reset", 32'(ibus_cyc), 32'd1);
      assert (ibus_adr == RESET_PC) else flag_mismatch("reset address", ibus_adr, RESET_PC);
      assert (!rf_read.rreq) else flag_mismatch("rreq in reset", 32'(rf_read.rreq), '0);
      assert (!rf_write.wen) else flag_mismatch("wen in reset", 32'(rf_write.wen), '0);
      rst_n <= 1'b1;
      wait (retired >= NUM_INSTR);
      @(negedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
qerv_pkg.sv
qerv_state.sv
qerv_decode.sv
qerv_immdec.sv
qerv_alu.sv
qerv_ctrl.sv
qerv_rf_if.sv
qerv_top.sv
tb_clk_gen.sv
tb_qerv.sv

// File: run.sh
#!/bin/sh
# Build and run the qerv testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_qerv -Mdir obj_dir -f project.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_qerv
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0
